/* design/tinker_isa_pkg.sv */
package tinker_isa_pkg;

    // word types
    typedef logic [63:0] xlen_t;  // register and data word
    typedef logic [31:0] inst_t;  // one instruction
    typedef logic [31:0] addr_t;  // byte address

    localparam int op_w      = 5;
    localparam int reg_idx_w = 5;
    localparam int lit_w     = 12;

    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [lit_w-1:0]     lit_t;

    // low bit of each field, L sits at the bottom
    localparam int op_lsb = 27;
    localparam int rd_lsb = 22;
    localparam int rs_lsb = 17;
    localparam int rt_lsb = 12;

    localparam int inst_bytes = 4;  // fetch size, pc step
    localparam int xlen_bytes = 8;  // load / store size

    // kept subset of the tinker opcode map
    typedef enum logic [op_w-1:0] {
        op_and     = 5'h00,
        op_or      = 5'h01,
        op_xor     = 5'h02,
        op_not     = 5'h03,
        op_shftr   = 5'h04,
        op_shftri  = 5'h05,
        op_shftl   = 5'h06,
        op_shftli  = 5'h07,
        op_br      = 5'h08,  // pc = rd
        op_brr_rd  = 5'h09,  // pc += rd
        op_brr_lit = 5'h0a,  // pc += sext(L)
        op_brnz    = 5'h0b,
        op_brgt    = 5'h0e,
        op_halt    = 5'h0f,
        op_load    = 5'h10,  // mov rd,(rs)(L)
        op_mov_rr  = 5'h11,
        op_mov_lit = 5'h12,
        op_store   = 5'h13,  // mov (rd)(L),rs
        op_add     = 5'h18,
        op_addi    = 5'h19,
        op_sub     = 5'h1a,
        op_subi    = 5'h1b
    } opcode_e;

endpackage

/* design/tinker_pipe_pkg.sv */
package tinker_pipe_pkg;

    import tinker_isa_pkg::*;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwd_none  = 2'd0,  // value read in decode
        fwd_exmem = 2'd1,  // result one stage ahead
        fwd_memwb = 2'd2   // writeback data
    } fwd_sel_e;

    // mov r0,r0 used for flush and halt fill
    // rewrites r0 with its own value so it has no effect
    localparam inst_t nop_inst = {op_mov_rr, 27'd0};

endpackage

/* design/unified_memory.sv */
module unified_memory import tinker_isa_pkg::*; #(
    parameter int mem_bytes = 512 * 1024
) (
    input  logic  clk,
    input  addr_t fetch_addr,
    output inst_t fetch_inst,
    input  addr_t load_addr,
    output xlen_t load_data,
    input  logic  store_we,
    input  addr_t store_addr,
    input  xlen_t store_data,
    input  logic  host_we,
    input  addr_t host_addr,
    input  inst_t host_wdata,
    output xlen_t host_rdata
);

    logic [7:0] mem [mem_bytes];  // byte array, contents come from the host

    // writes at the edge, little endian
    always_ff @(posedge clk) begin
        if (store_we) begin
            for (int i = 0; i < xlen_bytes; i++) begin
                mem[store_addr + addr_t'(i)] <= store_data[8*i +: 8];
            end
        end
        // host only writes while the core sits in reset
        if (host_we) begin
            for (int i = 0; i < inst_bytes; i++) begin
                mem[host_addr + addr_t'(i)] <= host_wdata[8*i +: 8];
            end
        end
    end

    // all reads combinational
    always_comb begin
        for (int i = 0; i < inst_bytes; i++) begin
            fetch_inst[8*i +: 8] = mem[fetch_addr + addr_t'(i)];  // 4 byte fetch
        end
        for (int i = 0; i < xlen_bytes; i++) begin
            load_data[8*i +: 8]  = mem[load_addr + addr_t'(i)];
            host_rdata[8*i +: 8] = mem[host_addr + addr_t'(i)];  // readback port
        end
    end

endmodule

/* design/reg_file.sv */
module reg_file import tinker_isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     we,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data,
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output xlen_t    rd_val,
    output xlen_t    rs_val,
    output xlen_t    rt_val
);

    localparam int num_regs = 2 ** reg_idx_w;

    xlen_t regs [num_regs];

    // one read port, writeback data bypasses the array
    function automatic xlen_t read_port(reg_idx_t idx);
        if (we && (wr_idx == idx)) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;  // all zero, r31 included
            end
        end else if (we) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // decode reads rd too, the immediate forms use it as a source
    always_comb begin
        rd_val = read_port(rd_idx);
        rs_val = read_port(rs_idx);
        rt_val = read_port(rt_idx);
    end

endmodule

/* design/decode_control.sv */
module decode_control import tinker_isa_pkg::*; (
    input  inst_t    inst,
    input  addr_t    pc,
    input  xlen_t    rd_val,
    input  xlen_t    rs_val,
    input  xlen_t    rt_val,
    output opcode_e  opcode,
    output reg_idx_t rd_idx,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output lit_t     lit,
    output logic     reg_write,
    output logic     mem_read,
    output logic     mem_write,
    output logic     mem_to_reg,
    output logic     halt,
    output logic     is_branch,
    output logic     take_branch,
    output addr_t    branch_target
);

    addr_t lit_sext;  // L widened for brr L

    // field split
    assign opcode   = opcode_e'(inst[op_lsb +: op_w]);
    assign rd_idx   = inst[rd_lsb +: reg_idx_w];
    assign rs_idx   = inst[rs_lsb +: reg_idx_w];
    assign rt_idx   = inst[rt_lsb +: reg_idx_w];
    assign lit      = inst[lit_w-1:0];
    assign lit_sext = addr_t'($signed(lit));

    // control bits, anything unlisted decodes as a nop
    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        halt       = 1'b0;
        is_branch  = 1'b0;
        case (opcode)
            op_add, op_addi, op_sub, op_subi,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_rr, op_mov_lit: begin
                reg_write = 1'b1;  // plain alu result into rd
            end
            op_load: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            op_store: mem_write = 1'b1;
            op_br, op_brr_rd, op_brr_lit, op_brnz, op_brgt: is_branch = 1'b1;
            op_halt: halt = 1'b1;
            default: ;
        endcase
    end

    // branch resolved here, one bubble behind a taken one
    // stale operands are kept out by the hazard stall
    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc + addr_t'(inst_bytes);
        case (opcode)
            op_br: begin
                take_branch   = 1'b1;
                branch_target = addr_t'(rd_val);
            end
            op_brr_rd: begin
                take_branch   = 1'b1;
                branch_target = pc + addr_t'(rd_val);  // relative to this pc
            end
            op_brr_lit: begin
                take_branch   = 1'b1;
                branch_target = pc + lit_sext;
            end
            op_brnz: begin
                take_branch   = (rs_val != '0);
                branch_target = addr_t'(rd_val);
            end
            op_brgt: begin
                take_branch   = ($signed(rs_val) > $signed(rt_val));  // signed compare
                branch_target = addr_t'(rd_val);
            end
            default: ;
        endcase
    end

endmodule

/* design/hazard_forward.sv */
module hazard_forward import tinker_isa_pkg::*, tinker_pipe_pkg::*; (
    input  reg_idx_t rd_idx,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     is_branch,
    input  reg_idx_t idex_rd,
    input  logic     idex_reg_write,
    input  logic     idex_mem_read,
    input  reg_idx_t idex_rd_src,
    input  reg_idx_t idex_rs_src,
    input  reg_idx_t idex_rt_src,
    input  reg_idx_t exmem_rd,
    input  logic     exmem_reg_write,
    input  logic     exmem_mem_read,
    input  reg_idx_t memwb_rd,
    input  logic     memwb_reg_write,
    output logic     stall,
    output fwd_sel_e sel_rd,
    output fwd_sel_e sel_rs,
    output fwd_sel_e sel_rt
);

    logic idex_hit, exmem_hit;  // decode sources match a pending dest
    logic load_use, branch_wait;

    // all three fields count as sources, a few extra stalls at most
    assign idex_hit  = (idex_rd == rd_idx) || (idex_rd == rs_idx) || (idex_rd == rt_idx);
    assign exmem_hit = (exmem_rd == rd_idx) || (exmem_rd == rs_idx) || (exmem_rd == rt_idx);

    assign load_use    = idex_mem_read && idex_hit;
    // branch compares in decode, so nothing in EX or MEM may feed it
    assign branch_wait = is_branch &&
                         ((idex_reg_write && idex_hit) ||
                          ((exmem_reg_write || exmem_mem_read) && exmem_hit));
    assign stall = load_use || branch_wait;

    // newest producer wins
    function automatic fwd_sel_e pick(reg_idx_t src);
        if (exmem_reg_write && (exmem_rd == src)) begin
            return fwd_exmem;
        end
        if (memwb_reg_write && (memwb_rd == src)) begin
            return fwd_memwb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        sel_rd = pick(idex_rd_src);  // rd is a source for the immediate forms and store
        sel_rs = pick(idex_rs_src);
        sel_rt = pick(idex_rt_src);
    end

endmodule

/* design/execute_alu.sv */
module execute_alu import tinker_isa_pkg::*, tinker_pipe_pkg::*; (
    input  opcode_e  opcode,
    input  lit_t     lit,
    input  xlen_t    rd_reg,
    input  xlen_t    rs_reg,
    input  xlen_t    rt_reg,
    input  fwd_sel_e sel_rd,
    input  fwd_sel_e sel_rs,
    input  fwd_sel_e sel_rt,
    input  xlen_t    exmem_result,
    input  xlen_t    wb_data,
    output xlen_t    result,
    output xlen_t    store_val
);

    xlen_t rd_op, rs_op, rt_op;  // operands after forwarding
    xlen_t lit_zext, lit_sext;

    function automatic xlen_t fwd_mux(fwd_sel_e sel, xlen_t reg_val);
        case (sel)
            fwd_exmem: return exmem_result;
            fwd_memwb: return wb_data;  // covers loaded data too
            default:   return reg_val;
        endcase
    endfunction

    always_comb begin
        rd_op = fwd_mux(sel_rd, rd_reg);
        rs_op = fwd_mux(sel_rs, rs_reg);
        rt_op = fwd_mux(sel_rt, rt_reg);
    end

    assign lit_zext  = xlen_t'(lit);           // addi, subi, shift counts
    assign lit_sext  = xlen_t'($signed(lit));  // memory offsets
    assign store_val = rs_op;

    always_comb begin
        result = '0;
        case (opcode)
            op_add:     result = rs_op + rt_op;
            op_addi:    result = rd_op + lit_zext;
            op_sub:     result = rs_op - rt_op;
            op_subi:    result = rd_op - lit_zext;
            op_and:     result = rs_op & rt_op;
            op_or:      result = rs_op | rt_op;
            op_xor:     result = rs_op ^ rt_op;
            op_not:     result = ~rs_op;  // rt unused
            op_shftr:   result = rs_op >> rt_op;
            op_shftri:  result = rd_op >> lit_zext;
            op_shftl:   result = rs_op << rt_op;
            op_shftli:  result = rd_op << lit_zext;
            op_mov_rr:  result = rs_op;
            op_mov_lit: result = {rd_op[63:lit_w], lit};  // only the low 12 bits change
            op_load:    result = rs_op + lit_sext;         // address
            op_store:   result = rd_op + lit_sext;         // address
            default:    result = '0;
        endcase
    end

endmodule

/* design/tinker_core.sv */
module tinker_core import tinker_isa_pkg::*, tinker_pipe_pkg::*; #(
    parameter addr_t pc_reset_addr = 32'h2000,
    parameter int    mem_bytes     = 512 * 1024
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  host_we,
    input  addr_t host_addr,
    input  inst_t host_wdata,
    output xlen_t host_rdata,
    output logic  hlt
);

    addr_t pc, if_pc, id_target;
    inst_t fetch_inst, if_inst;
    logic  stall, redirect, halt_seen;

    // decode side
    opcode_e  id_opcode;
    reg_idx_t id_rd, id_rs, id_rt;
    lit_t     id_lit;
    xlen_t    rf_rd, rf_rs, rf_rt;
    logic     id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg, id_halt;
    logic     id_is_branch, id_take;
    fwd_sel_e sel_rd, sel_rs, sel_rt;

    // ID/EX
    logic     idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg, idex_halt;
    opcode_e  idex_opcode;
    reg_idx_t idex_rd, idex_rs, idex_rt;
    lit_t     idex_lit;
    xlen_t    idex_rd_val, idex_rs_val, idex_rt_val;
    xlen_t    ex_result, ex_store_val;

    // EX/MEM and MEM/WB
    logic     exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg, exmem_halt;
    xlen_t    exmem_result, exmem_store_val, load_data;
    reg_idx_t exmem_rd, memwb_rd;
    logic     memwb_reg_write, memwb_mem_to_reg;
    xlen_t    memwb_load, memwb_result, wb_data;

    unified_memory #(.mem_bytes(mem_bytes)) u_mem (
        .clk(clk), .fetch_addr(pc), .fetch_inst(fetch_inst),
        .load_addr(addr_t'(exmem_result)), .load_data(load_data),
        .store_we(exmem_mem_write), .store_addr(addr_t'(exmem_result)),
        .store_data(exmem_store_val),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata)
    );

    // fetch: taken branch wins, halt in decode or behind us freezes the pc
    assign redirect = id_take && !stall && !halt_seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc        <= pc_reset_addr;
            if_pc     <= pc_reset_addr;
            if_inst   <= nop_inst;
            halt_seen <= 1'b0;
        end else if (!stall) begin
            if (redirect) begin
                pc <= id_target;
            end else if (!halt_seen && !id_halt) begin
                pc <= pc + addr_t'(inst_bytes);
            end
            if_pc     <= pc;
            if_inst   <= (redirect || halt_seen || id_halt) ? nop_inst : fetch_inst;  // flush / fill
            halt_seen <= halt_seen || id_halt;  // sticky until reset
        end
    end

    decode_control u_dec (
        .inst(if_inst), .pc(if_pc), .rd_val(rf_rd), .rs_val(rf_rs), .rt_val(rf_rt),
        .opcode(id_opcode), .rd_idx(id_rd), .rs_idx(id_rs), .rt_idx(id_rt), .lit(id_lit),
        .reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
        .mem_to_reg(id_mem_to_reg), .halt(id_halt), .is_branch(id_is_branch),
        .take_branch(id_take), .branch_target(id_target)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset), .we(memwb_reg_write), .wr_idx(memwb_rd), .wr_data(wb_data),
        .rd_idx(id_rd), .rs_idx(id_rs), .rt_idx(id_rt),
        .rd_val(rf_rd), .rs_val(rf_rs), .rt_val(rf_rt)
    );

    hazard_forward u_haz (
        .rd_idx(id_rd), .rs_idx(id_rs), .rt_idx(id_rt), .is_branch(id_is_branch),
        .idex_rd(idex_rd), .idex_reg_write(idex_reg_write), .idex_mem_read(idex_mem_read),
        .idex_rd_src(idex_rd), .idex_rs_src(idex_rs), .idex_rt_src(idex_rt),
        .exmem_rd(exmem_rd), .exmem_reg_write(exmem_reg_write),
        .exmem_mem_read(exmem_mem_read),
        .memwb_rd(memwb_rd), .memwb_reg_write(memwb_reg_write),
        .stall(stall), .sel_rd(sel_rd), .sel_rs(sel_rs), .sel_rt(sel_rt)
    );

    // ID/EX control, a stall leaves a bubble
    always_ff @(posedge clk or posedge reset) begin
        if (reset || stall) begin
            {idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg, idex_halt} <= '0;
        end else begin
            idex_reg_write  <= id_reg_write;
            idex_mem_read   <= id_mem_read;
            idex_mem_write  <= id_mem_write;
            idex_mem_to_reg <= id_mem_to_reg;
            idex_halt       <= id_halt;
        end
    end

    always_ff @(posedge clk) begin
        idex_opcode <= id_opcode;
        idex_rd     <= id_rd;
        idex_rs     <= id_rs;
        idex_rt     <= id_rt;
        idex_lit    <= id_lit;
        idex_rd_val <= rf_rd;
        idex_rs_val <= rf_rs;
        idex_rt_val <= rf_rt;
    end

    execute_alu u_alu (
        .opcode(idex_opcode), .lit(idex_lit),
        .rd_reg(idex_rd_val), .rs_reg(idex_rs_val), .rt_reg(idex_rt_val),
        .sel_rd(sel_rd), .sel_rs(sel_rs), .sel_rt(sel_rt),
        .exmem_result(exmem_result), .wb_data(wb_data),
        .result(ex_result), .store_val(ex_store_val)
    );

    // EX/MEM, MEM/WB control and the sticky hlt
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg} <= '0;
            exmem_halt       <= 1'b0;
            memwb_reg_write  <= 1'b0;
            memwb_mem_to_reg <= 1'b0;
            hlt              <= 1'b0;
        end else begin
            exmem_reg_write  <= idex_reg_write;
            exmem_mem_read   <= idex_mem_read;
            exmem_mem_write  <= idex_mem_write;
            exmem_mem_to_reg <= idex_mem_to_reg;
            exmem_halt       <= idex_halt;
            memwb_reg_write  <= exmem_reg_write;
            memwb_mem_to_reg <= exmem_mem_to_reg;
            hlt              <= hlt || exmem_halt;  // rises as halt enters MEM/WB
        end
    end

    always_ff @(posedge clk) begin
        exmem_result    <= ex_result;  // also the memory address
        exmem_store_val <= ex_store_val;
        exmem_rd        <= idex_rd;
        memwb_load      <= load_data;
        memwb_result    <= exmem_result;
        memwb_rd        <= exmem_rd;
    end

    // writeback select
    assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_result;

endmodule

/* dv/tinker_programs.svh */
`ifndef tinker_programs_svh
`define tinker_programs_svh

    localparam int num_progs  = 5;
    localparam int prog_words = 16;  // words per program, loaded from the reset pc

    // hand encoded from the field map, op 31..27 rd 26..22 rs 21..17 rt 16..12 L 11..0
    localparam inst_t prog_table [num_progs][prog_words] = '{
        // alu chain
        '{32'h90400123, 32'hC8400005,  // mov r1,0x123; addi r1,5
          32'h908000F0, 32'hD0C22000,  // mov r2,0xf0; sub r3,r1,r2
          32'h11061000, 32'h39000008,  // xor r4,r3,r1; shftli r4,8
          32'h19480000, 32'h91800004,  // not r5,r4; mov r6,4
          32'h21CA6000, 32'h29C00008,  // shftr r7,r5,r6; shftri r7,8
          32'h320E6000, 32'hDA000010,  // shftl r8,r7,r6; subi r8,0x10
          32'h98100100, 32'h78000000,  // mov (r0)(0x100),r8; halt
          32'h78000000, 32'h78000000},
        // back to back producers and consumers in rd, rs, rt
        '{32'h90400011, 32'hC8400022,  // mov r1,0x11; addi r1,0x22
          32'h90800005, 32'hC8400001,  // mov r2,5; addi r1,1
          32'hC0C41000, 32'hC8800010,  // add r3,r2,r1; addi r2,0x10
          32'hD1062000, 32'h11423000,  // sub r4,r3,r2; xor r5,r1,r3
          32'hC1885000, 32'h39800004,  // add r6,r4,r5; shftli r6,4
          32'hC18C4000, 32'h91C00200,  // add r6,r6,r4; mov r7,0x200
          32'h99CC0010, 32'h78000000,  // mov (r7)(0x10),r6; halt
          32'h78000000, 32'h78000000},
        // store, load, use right away
        '{32'h904007AB, 32'h3840000C,  // mov r1,0x7ab; shftli r1,12
          32'hC8400321, 32'h98020300,  // addi r1,0x321; mov (r0)(0x300),r1
          32'h80800300, 32'hC0C41000,  // mov r2,(r0)(0x300); add r3,r2,r1
          32'h81000300, 32'hC9000001,  // mov r4,(r0)(0x300); addi r4,1
          32'hC1464000, 32'h980A0308,  // add r5,r3,r4; mov (r0)(0x308),r5
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000},
        // countdown loop, signed brgt both ways, brr skip
        '{32'h90800803, 32'h38800002,  // mov r2,0x803; shftli r2,2  loop head 0x200c
          32'h90400003, 32'hC8C00001,  // mov r1,3; loop: addi r3,1
          32'hD8400001, 32'h58820000,  // subi r1,1; brnz r2,r1
          32'h19800000, 32'hC8800024,  // not r6,r0; addi r2,0x24  now 0x2030
          32'h708C1000, 32'hC8C00010,  // brgt r2,r6,r1 falls through; addi r3,0x10
          32'h70826000, 32'hC8C00100,  // brgt r2,r1,r6 taken; addi r3,0x100 skipped
          32'h50000008, 32'hC8C00200,  // brr 8; addi r3,0x200 skipped
          32'h98060400, 32'h78000000}, // mov (r0)(0x400),r3; halt
        // stores after the halt must stay out of memory
        '{32'h904005A5, 32'h908000FF,  // mov r1,0x5a5; mov r2,0xff
          32'h98020500, 32'h78000000,  // mov (r0)(0x500),r1; halt
          32'h98040500, 32'h98040500,  // mov (r0)(0x500),r2 twice
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000,
          32'h78000000, 32'h78000000}
    };

    // where each program leaves its result, and the value worked out by hand
    localparam addr_t result_addr [num_progs] = '{
        32'h100, 32'h210, 32'h308, 32'h400, 32'h500
    };
    localparam xlen_t result_exp [num_progs] = '{
        64'h00FF_FFFF_FFFF_FED0,  // alu chain
        64'h0000_0000_0000_0334,
        64'h0000_0000_0170_1964,  // 2 * 0x7ab321 + 0x7ab322
        64'h0000_0000_0000_0013,  // 3 loop passes + 0x10
        64'h0000_0000_0000_05A5   // first store only
    };

`endif

/* dv/tinker_core_tb.sv */
module tinker_core_tb import tinker_isa_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t load_base   = 32'h2000;  // reset pc
    localparam int    reset_hold  = 5;         // cycles before loading
    localparam int    hlt_timeout = 500;
    localparam int    hold_cycles = 8;         // hlt watched after it rises

    `include "tinker_programs.svh"

    logic  clk;
    logic  reset;
    logic  host_we;
    addr_t host_addr;
    inst_t host_wdata;
    xlen_t host_rdata;
    logic  hlt;

    tinker_core #(
        .pc_reset_addr(load_base),
        .mem_bytes(512 * 1024)
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .host_we(host_we),
        .host_addr(host_addr),
        .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .hlt(hlt)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping on first error");
    endtask

    // the one compare used for every result
    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // 4 byte host write, taken at the rising edge in between
    task automatic host_write(input addr_t addr, input inst_t data);
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        @(negedge clk);
        host_we    = 1'b0;
    endtask

    task automatic wait_for_hlt();
        int cycles;
        cycles = 0;
        while (!hlt && (cycles < hlt_timeout)) begin
            @(negedge clk);  // sampled away from the rising edge
            cycles++;
        end
        if (!hlt) begin
            $display("timeout: hlt never rose within %0d cycles after reset", hlt_timeout);
            abort_run();
        end
    endtask

    task automatic run_program(input int idx);
        reset = 1'b1;
        repeat (reset_hold) @(negedge clk);
        check_value("hlt", xlen_t'(hlt), '0);  // sticky bit gone in reset
        for (int i = 0; i < prog_words; i++) begin
            host_write(load_base + addr_t'(4 * i), prog_table[idx][i]);
        end
        // clear the result doubleword, memory keeps old contents
        host_write(result_addr[idx], '0);
        host_write(result_addr[idx] + 32'd4, '0);
        host_addr = result_addr[idx];  // readback port parked here
        reset     = 1'b0;
        wait_for_hlt();
        check_value("host_rdata", host_rdata, result_exp[idx]);
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_value("hlt", xlen_t'(hlt), xlen_t'(1));  // stays up until reset
        end
        // nothing behind the halt may land
        check_value("host_rdata", host_rdata, result_exp[idx]);
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk        = 1'b0;
        reset      = 1'b1;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        for (int p = 0; p < num_progs; p++) begin
            run_program(p);
            $display("program %0d: 0x%h at 0x%h", p, host_rdata, result_addr[p]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* tinker_core.f */
+incdir+dv
design/tinker_isa_pkg.sv
design/tinker_pipe_pkg.sv
design/unified_memory.sv
design/reg_file.sv
design/decode_control.sv
design/hazard_forward.sv
design/execute_alu.sv
design/tinker_core.sv
dv/tinker_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build tinker_core_tb with verilator, run it, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tinker_core_tb \
    -f tinker_core.f -o tinker_sim &&
    ./obj_dir/tinker_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^PASS: all tests$" sim.log 2>/dev/null && echo "run_sim: passed" ||
    { echo "run_sim: failed"; exit 1; }
